// ==== verilog/demodMonitorPkg.sv ====
/* Demod monitor shared definitions */

package demodMonitorPkg;

    // datapath widths
    parameter int SampleWidthDefault = 18;
    parameter int DataWidth          = 32;
    parameter int AddrWidth          = 13;
    parameter int AlphaWidth         = 16;

    // DAC source codes, anything unlisted behaves as DacI
    typedef enum logic [3:0] {
        DacI          = 4'd0,
        DacQ          = 4'd1,
        DacFreq       = 4'd2,
        DacAvgFreq    = 4'd3,
        DacAvgAbsFreq = 4'd4
    } dacSelT;

    // register word offsets
    parameter logic [AddrWidth-1:0] RegDacSelect = 13'h000;
    parameter logic [AddrWidth-1:0] RegFalseLock = 13'h004;
    parameter logic [AddrWidth-1:0] RegStatus    = 13'h008;
    parameter logic [AddrWidth-1:0] RegAvgFreq   = 13'h00C;

endpackage

// ==== verilog/expAverager.sv ====
/* Exponential averager */

`timescale 1ns/1ps

module expAverager #(
    parameter int SampleWidth = demodMonitorPkg::SampleWidthDefault
) (
    input  logic                                    clk,
    input  logic                                    rstN,
    input  logic                                    updateEn,
    input  logic signed [SampleWidth-1:0]           sample,
    input  logic [demodMonitorPkg::AlphaWidth-1:0]  alpha,
    output logic signed [SampleWidth-1:0]           average
);

    localparam int AlphaWidth = demodMonitorPkg::AlphaWidth;
    localparam int ProdWidth  = 2 * SampleWidth + 1;
    // just under unity in the coefficient format
    localparam logic [SampleWidth-1:0] UnityMinusLsb = {1'b0, {(SampleWidth-1){1'b1}}};

    logic [SampleWidth-1:0]        coefA;
    logic [SampleWidth-1:0]        coefB;
    logic signed [SampleWidth-1:0] heldSample;
    logic signed [ProdWidth-1:0]   sampleProd;
    logic signed [ProdWidth-1:0]   averageProd;
    logic signed [ProdWidth-1:0]   sumProd;

    assign coefA = {alpha, {(SampleWidth-AlphaWidth){1'b0}}};
    assign coefB = UnityMinusLsb - coefA;

    // coefficients are positive, so give them a zero sign bit
    always_ff @(posedge clk) begin
        sampleProd  <= heldSample * $signed({1'b0, coefA});
        averageProd <= average * $signed({1'b0, coefB});
    end

    assign sumProd = sampleProd + averageProd;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            heldSample <= '0;
            average    <= '0;
        end else if (updateEn) begin
            heldSample <= sample;
            average    <= sumProd[2*SampleWidth-2:SampleWidth-1];
        end
    end

endmodule

// ==== verilog/falseLockDetector.sv ====
/* False lock detector */

`timescale 1ns/1ps

module falseLockDetector #(
    parameter int SampleWidth = demodMonitorPkg::SampleWidthDefault
) (
    input  logic                                    clk,
    input  logic                                    rstN,
    input  logic                                    freqEn,
    input  logic signed [SampleWidth-1:0]           fmVideo,
    input  logic [demodMonitorPkg::AlphaWidth-1:0]  falseLockAlpha,
    input  logic [demodMonitorPkg::AlphaWidth-1:0]  falseLockThreshold,
    input  logic                                    carrierLock,
    output logic signed [SampleWidth-1:0]           averageFreq,
    output logic signed [SampleWidth-1:0]           averageAbsFreq,
    output logic                                    highFreqOffset
);

    localparam int AlphaWidth = demodMonitorPkg::AlphaWidth;
    // half of full scale, 0x10000 at 18 bits
    localparam logic [SampleWidth-1:0] AbsLimit = {2'b01, {(SampleWidth-2){1'b0}}};

    logic signed [SampleWidth-1:0] absSample;
    logic [SampleWidth-1:0]        absAverageFreq;
    logic [SampleWidth-1:0]        thresholdExt;

    // most negative code wraps back onto itself
    assign absSample = fmVideo[SampleWidth-1] ? -fmVideo : fmVideo;

    expAverager #(
        .SampleWidth(SampleWidth)
    ) freqAverager_inst (
        .clk(clk),
        .rstN(rstN),
        .updateEn(freqEn),
        .sample(fmVideo),
        .alpha(falseLockAlpha),
        .average(averageFreq)
    );

    expAverager #(
        .SampleWidth(SampleWidth)
    ) absFreqAverager_inst (
        .clk(clk),
        .rstN(rstN),
        .updateEn(freqEn),
        .sample(absSample),
        .alpha(falseLockAlpha),
        .average(averageAbsFreq)
    );

    assign absAverageFreq = averageFreq[SampleWidth-1] ? -averageFreq : averageFreq;
    assign thresholdExt   = {{(SampleWidth-AlphaWidth){1'b0}}, falseLockThreshold};

    // wide spread of frequencies always flags, a steady offset only when unlocked
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            highFreqOffset <= 1'b0;
        end else if (freqEn) begin
            if ($unsigned(averageAbsFreq) > AbsLimit) begin
                highFreqOffset <= 1'b1;
            end else if (absAverageFreq > thresholdExt) begin
                highFreqOffset <= !carrierLock;
            end else begin
                highFreqOffset <= 1'b0;
            end
        end
    end

endmodule

// ==== verilog/iqFrontEnd.sv ====
/* I/Q swap and FM discriminator */

`timescale 1ns/1ps

module iqFrontEnd #(
    parameter int SampleWidth = demodMonitorPkg::SampleWidthDefault
) (
    input  logic                          clk,
    input  logic                          rstN,
    input  logic                          sampleEn,
    input  logic signed [SampleWidth-1:0] iIn,
    input  logic signed [SampleWidth-1:0] qIn,
    input  logic                          iqSwap,
    output logic signed [SampleWidth-1:0] iSwap,
    output logic signed [SampleWidth-1:0] qSwap,
    output logic signed [SampleWidth-1:0] fmVideo,
    output logic                          freqEn
);

    localparam int ProdWidth = 2 * SampleWidth;

    logic signed [SampleWidth-1:0] iPrev;
    logic signed [SampleWidth-1:0] qPrev;
    // i0*q1 and q0*i1
    logic signed [ProdWidth-1:0]   crossIQ;
    logic signed [ProdWidth-1:0]   crossQI;
    logic signed [ProdWidth-1:0]   crossDiff;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            iPrev  <= '0;
            qPrev  <= '0;
            freqEn <= 1'b0;
        end else begin
            freqEn <= sampleEn;
            if (sampleEn) begin
                iPrev <= iIn;
                qPrev <= qIn;
            end
        end
    end

    // discriminator works on the unswapped pair
    always_ff @(posedge clk) begin
        if (sampleEn) begin
            crossIQ <= iPrev * qIn;
            crossQI <= qPrev * iIn;
            iSwap   <= iqSwap ? qIn : iIn;
            qSwap   <= iqSwap ? iIn : qIn;
        end
    end

    assign crossDiff = crossIQ - crossQI;
    // drop the redundant sign bit, keep the top half
    assign fmVideo   = crossDiff[ProdWidth-2:SampleWidth-1];

endmodule

// ==== verilog/dacChannel.sv ====
/* DAC output selector */

`timescale 1ns/1ps

module dacChannel #(
    parameter int SampleWidth = demodMonitorPkg::SampleWidthDefault
) (
    input  logic                          clk,
    input  logic                          rstN,
    input  demodMonitorPkg::dacSelT       dacSelect,
    input  logic                          sampleEn,
    input  logic                          freqEn,
    input  logic signed [SampleWidth-1:0] iSwap,
    input  logic signed [SampleWidth-1:0] qSwap,
    input  logic signed [SampleWidth-1:0] fmVideo,
    input  logic signed [SampleWidth-1:0] averageFreq,
    input  logic signed [SampleWidth-1:0] averageAbsFreq,
    output logic [SampleWidth-1:0]        dacData,
    output logic                          dacSync
);

    logic [SampleWidth-1:0] nextData;
    logic                   nextSync;

    // I/Q registers are read at the strobe, so they carry the previous pair
    always_comb begin
        case (dacSelect)
            demodMonitorPkg::DacI: begin
                nextData = iSwap;
                nextSync = sampleEn;
            end
            demodMonitorPkg::DacQ: begin
                nextData = qSwap;
                nextSync = sampleEn;
            end
            demodMonitorPkg::DacFreq: begin
                nextData = fmVideo;
                nextSync = freqEn;
            end
            demodMonitorPkg::DacAvgFreq: begin
                nextData = averageFreq;
                nextSync = freqEn;
            end
            demodMonitorPkg::DacAvgAbsFreq: begin
                nextData = averageAbsFreq;
                nextSync = freqEn;
            end
            default: begin
                nextData = iSwap;
                nextSync = sampleEn;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        dacData <= nextData;
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            dacSync <= 1'b0;
        end else begin
            dacSync <= nextSync;
        end
    end

endmodule

// ==== verilog/monitorRegs.sv ====
/* Monitor control and status registers */

`timescale 1ns/1ps

module monitorRegs #(
    parameter int SampleWidth = demodMonitorPkg::SampleWidthDefault
) (
    input  logic                                     clk,
    input  logic                                     rstN,
    input  logic [demodMonitorPkg::AddrWidth-1:0]    addr,
    input  logic [demodMonitorPkg::DataWidth-1:0]    din,
    input  logic                                     wr0,
    input  logic                                     wr1,
    input  logic                                     wr2,
    input  logic                                     wr3,
    input  logic                                     highFreqOffset,
    input  logic                                     carrierLock,
    input  logic signed [SampleWidth-1:0]            averageFreq,
    output logic [demodMonitorPkg::DataWidth-1:0]    dout,
    output demodMonitorPkg::dacSelT                  dac0Select,
    output demodMonitorPkg::dacSelT                  dac1Select,
    output demodMonitorPkg::dacSelT                  dac2Select,
    output logic                                     iqSwap,
    output logic [demodMonitorPkg::AlphaWidth-1:0]   falseLockAlpha,
    output logic [demodMonitorPkg::AlphaWidth-1:0]   falseLockThreshold
);

    localparam int DataWidth  = demodMonitorPkg::DataWidth;
    localparam int AlphaWidth = demodMonitorPkg::AlphaWidth;
    localparam int ByteLanes  = 4;

    logic [ByteLanes-1:0] byteWr;
    logic [DataWidth-1:0] dacSelectReg;
    logic [DataWidth-1:0] falseLockReg;

    // wr0 is the low byte
    assign byteWr = {wr3, wr2, wr1, wr0};

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            dacSelectReg <= '0;
            falseLockReg <= '0;
        end else begin
            for (int lane = 0; lane < ByteLanes; lane++) begin
                if (byteWr[lane]) begin
                    if (addr == demodMonitorPkg::RegDacSelect) begin
                        dacSelectReg[lane*8 +: 8] <= din[lane*8 +: 8];
                    end
                    if (addr == demodMonitorPkg::RegFalseLock) begin
                        falseLockReg[lane*8 +: 8] <= din[lane*8 +: 8];
                    end
                end
            end
        end
    end

    // select fields, one nibble per DAC
    assign dac0Select = demodMonitorPkg::dacSelT'(dacSelectReg[3:0]);
    assign dac1Select = demodMonitorPkg::dacSelT'(dacSelectReg[11:8]);
    assign dac2Select = demodMonitorPkg::dacSelT'(dacSelectReg[19:16]);
    assign iqSwap     = dacSelectReg[24];

    assign falseLockAlpha     = falseLockReg[AlphaWidth-1:0];
    assign falseLockThreshold = falseLockReg[2*AlphaWidth-1:AlphaWidth];

    // readback mux
    always_comb begin
        case (addr)
            demodMonitorPkg::RegDacSelect: begin
                dout = dacSelectReg;
            end
            demodMonitorPkg::RegFalseLock: begin
                dout = falseLockReg;
            end
            demodMonitorPkg::RegStatus: begin
                dout = {{(DataWidth-2){1'b0}}, carrierLock, highFreqOffset};
            end
            demodMonitorPkg::RegAvgFreq: begin
                dout = {{(DataWidth-SampleWidth){averageFreq[SampleWidth-1]}}, averageFreq};
            end
            default: begin
                dout = '0;
            end
        endcase
    end

endmodule

// ==== verilog/demodMonitor.sv ====
/* Demodulator monitor top level */

`timescale 1ns/1ps

module demodMonitor #(
    parameter int SampleWidth = demodMonitorPkg::SampleWidthDefault
) (
    input  logic                                     clk,
    input  logic                                     rstN,
    input  logic [demodMonitorPkg::AddrWidth-1:0]    addr,
    input  logic [demodMonitorPkg::DataWidth-1:0]    din,
    input  logic                                     wr0,
    input  logic                                     wr1,
    input  logic                                     wr2,
    input  logic                                     wr3,
    input  logic                                     sampleEn,
    input  logic signed [SampleWidth-1:0]            iIn,
    input  logic signed [SampleWidth-1:0]            qIn,
    input  logic                                     carrierLock,
    output logic [demodMonitorPkg::DataWidth-1:0]    dout,
    output logic [SampleWidth-1:0]                   dac0Data,
    output logic [SampleWidth-1:0]                   dac1Data,
    output logic [SampleWidth-1:0]                   dac2Data,
    output logic                                     dac0Sync,
    output logic                                     dac1Sync,
    output logic                                     dac2Sync,
    output logic                                     highFreqOffset
);

    demodMonitorPkg::dacSelT                     dac0Select;
    demodMonitorPkg::dacSelT                     dac1Select;
    demodMonitorPkg::dacSelT                     dac2Select;
    logic                                        iqSwap;
    logic [demodMonitorPkg::AlphaWidth-1:0]      falseLockAlpha;
    logic [demodMonitorPkg::AlphaWidth-1:0]      falseLockThreshold;
    logic signed [SampleWidth-1:0]               iSwap;
    logic signed [SampleWidth-1:0]               qSwap;
    logic signed [SampleWidth-1:0]               fmVideo;
    logic                                        freqEn;
    logic signed [SampleWidth-1:0]               averageFreq;
    logic signed [SampleWidth-1:0]               averageAbsFreq;

    monitorRegs #(
        .SampleWidth(SampleWidth)
    ) monitorRegs_inst (
        .clk(clk),
        .rstN(rstN),
        .addr(addr),
        .din(din),
        .wr0(wr0),
        .wr1(wr1),
        .wr2(wr2),
        .wr3(wr3),
        .highFreqOffset(highFreqOffset),
        .carrierLock(carrierLock),
        .averageFreq(averageFreq),
        .dout(dout),
        .dac0Select(dac0Select),
        .dac1Select(dac1Select),
        .dac2Select(dac2Select),
        .iqSwap(iqSwap),
        .falseLockAlpha(falseLockAlpha),
        .falseLockThreshold(falseLockThreshold)
    );

    iqFrontEnd #(
        .SampleWidth(SampleWidth)
    ) iqFrontEnd_inst (
        .clk(clk),
        .rstN(rstN),
        .sampleEn(sampleEn),
        .iIn(iIn),
        .qIn(qIn),
        .iqSwap(iqSwap),
        .iSwap(iSwap),
        .qSwap(qSwap),
        .fmVideo(fmVideo),
        .freqEn(freqEn)
    );

    falseLockDetector #(
        .SampleWidth(SampleWidth)
    ) falseLockDetector_inst (
        .clk(clk),
        .rstN(rstN),
        .freqEn(freqEn),
        .fmVideo(fmVideo),
        .falseLockAlpha(falseLockAlpha),
        .falseLockThreshold(falseLockThreshold),
        .carrierLock(carrierLock),
        .averageFreq(averageFreq),
        .averageAbsFreq(averageAbsFreq),
        .highFreqOffset(highFreqOffset)
    );

    // three identical DAC outputs
    dacChannel #(
        .SampleWidth(SampleWidth)
    ) dac0Channel_inst (
        .clk(clk),
        .rstN(rstN),
        .dacSelect(dac0Select),
        .sampleEn(sampleEn),
        .freqEn(freqEn),
        .iSwap(iSwap),
        .qSwap(qSwap),
        .fmVideo(fmVideo),
        .averageFreq(averageFreq),
        .averageAbsFreq(averageAbsFreq),
        .dacData(dac0Data),
        .dacSync(dac0Sync)
    );

    dacChannel #(
        .SampleWidth(SampleWidth)
    ) dac1Channel_inst (
        .clk(clk),
        .rstN(rstN),
        .dacSelect(dac1Select),
        .sampleEn(sampleEn),
        .freqEn(freqEn),
        .iSwap(iSwap),
        .qSwap(qSwap),
        .fmVideo(fmVideo),
        .averageFreq(averageFreq),
        .averageAbsFreq(averageAbsFreq),
        .dacData(dac1Data),
        .dacSync(dac1Sync)
    );

    dacChannel #(
        .SampleWidth(SampleWidth)
    ) dac2Channel_inst (
        .clk(clk),
        .rstN(rstN),
        .dacSelect(dac2Select),
        .sampleEn(sampleEn),
        .freqEn(freqEn),
        .iSwap(iSwap),
        .qSwap(qSwap),
        .fmVideo(fmVideo),
        .averageFreq(averageFreq),
        .averageAbsFreq(averageAbsFreq),
        .dacData(dac2Data),
        .dacSync(dac2Sync)
    );

endmodule

// ==== tb/monitorChecks.svh ====
/* Monitor compare tasks */

`ifndef MONITOR_CHECKS_SVH
`define MONITOR_CHECKS_SVH

int errorCount = 0;
int checkCount = 0;
int testErrors = 0;
int testChecks = 0;
int testCount  = 0;

task automatic checkWord(
    input string                                  what,
    input logic [demodMonitorPkg::DataWidth-1:0]  actual,
    input logic [demodMonitorPkg::DataWidth-1:0]  expected
);
    checkCount++;
    testChecks++;
    if (actual !== expected) begin
        errorCount++;
        testErrors++;
        $display("FAILED at %0t ns: %s read %h, expected %h", $time, what, actual, expected);
    end
endtask

task automatic checkDac(
    input int                                             channel,
    input logic [demodMonitorPkg::SampleWidthDefault-1:0] actual,
    input logic [demodMonitorPkg::SampleWidthDefault-1:0] expected
);
    checkCount++;
    testChecks++;
    if (actual !== expected) begin
        errorCount++;
        testErrors++;
        $display("FAILED at %0t ns: DAC %0d gave %h, expected %h", $time, channel, actual,
                 expected);
    end
endtask

task automatic checkFlag(
    input string what,
    input logic  actual,
    input logic  expected
);
    checkCount++;
    testChecks++;
    if (actual !== expected) begin
        errorCount++;
        testErrors++;
        $display("FAILED at %0t ns: %s was %b, expected %b", $time, what, actual, expected);
    end
endtask

`endif

// ==== tb/demodMonitorTb.sv ====
/* Demod monitor testbench */

`timescale 1ns/1ps

module demodMonitorTb;

    localparam int SampleWidth = demodMonitorPkg::SampleWidthDefault;
    localparam int ClkPeriod   = 100;

    `include "monitorChecks.svh"

    logic                                  clk;
    logic                                  rstN;
    logic [demodMonitorPkg::AddrWidth-1:0] addr;
    logic [demodMonitorPkg::DataWidth-1:0] din;
    logic                                  wr0;
    logic                                  wr1;
    logic                                  wr2;
    logic                                  wr3;
    logic                                  sampleEn;
    logic signed [SampleWidth-1:0]         iIn;
    logic signed [SampleWidth-1:0]         qIn;
    logic                                  carrierLock;
    logic [demodMonitorPkg::DataWidth-1:0] dout;
    logic [SampleWidth-1:0]                dac0Data;
    logic [SampleWidth-1:0]                dac1Data;
    logic [SampleWidth-1:0]                dac2Data;
    logic                                  dac0Sync;
    logic                                  dac1Sync;
    logic                                  dac2Sync;
    logic                                  highFreqOffset;

    // golden records
    int          recTest[$];
    int          recKind[$];
    logic [31:0] recA[$];
    logic [31:0] recB[$];
    logic [31:0] recC[$];
    bit          loaded = 0;

    // last value seen on each DAC sync pulse
    logic [SampleWidth-1:0] dacCapture[3];
    bit                     dacSeen[3];

    demodMonitor #(
        .SampleWidth(SampleWidth)
    ) demodMonitor_inst (
        .clk(clk), .rstN(rstN), .addr(addr), .din(din),
        .wr0(wr0), .wr1(wr1), .wr2(wr2), .wr3(wr3),
        .sampleEn(sampleEn), .iIn(iIn), .qIn(qIn), .carrierLock(carrierLock),
        .dout(dout), .dac0Data(dac0Data), .dac1Data(dac1Data), .dac2Data(dac2Data),
        .dac0Sync(dac0Sync), .dac1Sync(dac1Sync), .dac2Sync(dac2Sync),
        .highFreqOffset(highFreqOffset)
    );

    initial begin
        clk = 1'b0;
        forever #(ClkPeriod/2) clk = ~clk;
    end

    always @(negedge clk) begin
        if (dac0Sync) begin
            dacCapture[0] = dac0Data;
            dacSeen[0]    = 1;
        end
        if (dac1Sync) begin
            dacCapture[1] = dac1Data;
            dacSeen[1]    = 1;
        end
        if (dac2Sync) begin
            dacCapture[2] = dac2Data;
            dacSeen[2]    = 1;
        end
    end

    // limit scales with the number of records
    initial begin
        longint limitCycles;
        wait (loaded);
        limitCycles = recTest.size() * 8 + 20;
        #(limitCycles * ClkPeriod);
        $display("timeout: the run did not finish within %0d clock cycles", limitCycles);
        $display("TEST FAIL");
        $finish;
    end

    task automatic writeReg(input logic [31:0] a, input logic [31:0] d, input logic [3:0] lanes);
        @(negedge clk);
        addr = a[demodMonitorPkg::AddrWidth-1:0];
        din  = d;
        {wr3, wr2, wr1, wr0} = lanes;
        @(negedge clk);
        {wr3, wr2, wr1, wr0} = 4'b0000;
    endtask

    // one strobe, then wait out the 4-cycle spacing
    task automatic driveSample(input logic [31:0] i, input logic [31:0] q, input logic lock);
        @(negedge clk);
        dacSeen     = '{0, 0, 0};
        iIn         = i[SampleWidth-1:0];
        qIn         = q[SampleWidth-1:0];
        carrierLock = lock;
        sampleEn    = 1'b1;
        @(negedge clk);
        sampleEn = 1'b0;
        repeat (3) @(negedge clk);
    endtask

    task automatic readReg(input logic [31:0] a, input logic [31:0] expected);
        string what;
        @(negedge clk);
        addr = a[demodMonitorPkg::AddrWidth-1:0];
        @(negedge clk);
        what = $sformatf("register %h", addr);
        checkWord(what, dout, expected);
        // the status flag also leaves the top level on its own pin
        if (addr == demodMonitorPkg::RegStatus) begin
            checkFlag("highFreqOffset output", highFreqOffset, expected[0]);
        end
    endtask

    task automatic expectDac(input int channel, input logic [31:0] expected);
        int waited;
        waited = 0;
        while (!dacSeen[channel] && waited < 8) begin
            @(negedge clk);
            waited++;
        end
        if (!dacSeen[channel]) begin
            errorCount++;
            testErrors++;
            $display("no sync pulse seen on DAC %0d at %0t ns", channel, $time);
        end else begin
            checkDac(channel, dacCapture[channel], expected[SampleWidth-1:0]);
        end
    endtask

    task automatic reportTest(input int number);
        testCount++;
        $display("test %0d done: %0d checks, %0d errors", number, testChecks, testErrors);
        testChecks = 0;
        testErrors = 0;
    endtask

    initial begin
        int          fd;
        int          got;
        int          t;
        int          k;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        string       lineText;
        int          curTest;
        rstN        = 1'b0;
        addr        = '0;
        din         = '0;
        {wr3, wr2, wr1, wr0} = 4'b0000;
        sampleEn    = 1'b0;
        iIn         = '0;
        qIn         = '0;
        carrierLock = 1'b0;
        dacSeen     = '{0, 0, 0};
        fd = $fopen("tb/demodMonitorGolden.txt", "r");
        if (fd == 0) begin
            $display("could not open the golden file tb/demodMonitorGolden.txt");
            $display("TEST FAIL");
            $finish;
        end else begin
            while (!$feof(fd)) begin
                lineText = "";
                got = $fgets(lineText, fd);
                if (got > 1 && lineText.getc(0) != "#") begin
                    got = $sscanf(lineText, "%d %d %h %h %h", t, k, a, b, c);
                    if (got == 5) begin
                        recTest.push_back(t);
                        recKind.push_back(k);
                        recA.push_back(a);
                        recB.push_back(b);
                        recC.push_back(c);
                    end
                end
            end
            $fclose(fd);
            loaded = 1;
            repeat (4) @(negedge clk);
            rstN = 1'b1;
            curTest = 0;
            foreach (recTest[n]) begin
                if (recTest[n] != curTest && curTest != 0) begin
                    reportTest(curTest);
                end
                curTest = recTest[n];
                case (recKind[n])
                    0: writeReg(recA[n], recB[n], recC[n][3:0]);
                    1: driveSample(recA[n], recB[n], recC[n][0]);
                    2: readReg(recA[n], recB[n]);
                    default: expectDac(recA[n], recB[n]);
                endcase
            end
            if (curTest != 0) begin
                reportTest(curTest);
            end
            $display("summary: %0d tests, %0d checks, %0d errors", testCount, checkCount,
                     errorCount);
            if (errorCount == 0 && checkCount > 0) begin
                $display("TEST PASS");
            end else begin
                $display("TEST FAIL");
            end
            $finish;
        end
    end

endmodule

// ==== list.f ====
+incdir+tb
verilog/demodMonitorPkg.sv
verilog/expAverager.sv
verilog/falseLockDetector.sv
verilog/iqFrontEnd.sv
verilog/dacChannel.sv
verilog/monitorRegs.sv
verilog/demodMonitor.sv
tb/demodMonitorTb.sv

// ==== tb/demodMonitorGolden.txt ====
# test kind a b c, kinds 0 write(addr data strobes) 1 sample(i q lock)
# 2 read(addr expected 0) 3 dac(channel expected 0), values in hex
1 2 000 00000000 0
1 2 004 00000000 0
1 2 008 00000000 0
1 2 00C 00000000 0
1 2 010 00000000 0
1 0 000 12345678 5
1 2 000 00340078 0
1 0 004 AABBCCDD A
1 2 004 AA00CC00 0
1 1 00000 00000 1
1 2 008 00000002 0
1 1 00000 00000 0
1 2 008 00000000 0
2 0 004 00000000 F
2 0 000 00050100 F
2 1 00111 00222 0
2 3 0 00000 0
2 3 1 00000 0
2 3 2 00000 0
2 1 00333 00444 0
2 3 0 00111 0
2 3 1 00222 0
2 3 2 00111 0
2 0 000 01050100 F
2 1 00555 00666 0
2 3 0 00333 0
2 3 1 00444 0
2 1 00777 00888 0
2 3 0 00666 0
2 3 1 00555 0
2 3 2 00666 0
3 0 000 00020002 F
3 1 10000 00000 0
3 3 0 3FBBC 0
3 3 2 3FBBC 0
3 1 00000 10000 0
3 3 0 08000 0
3 3 1 10000 0
3 1 30000 00000 0
3 3 0 08000 0
3 1 00003 00005 0
3 3 0 3FFFD 0
3 3 2 3FFFD 0
4 0 004 FFFF7FFF F
4 0 000 00000403 F
4 1 10000 00000 0
4 1 00000 10000 0
4 1 30000 00000 0
4 3 0 3FFFD 0
4 3 1 00002 0
4 1 00000 30000 0
4 3 0 07FFE 0
4 3 1 07FFF 0
4 2 00C 00007FFF 0
4 1 10000 00000 0
4 3 0 07FFF 0
4 2 00C 00007FFF 0
4 2 008 00000000 0
5 0 004 40007FFF F
5 1 00000 10000 0
5 2 008 00000001 0
5 1 30000 00000 1
5 2 008 00000002 0
5 1 00000 30000 0
5 2 008 00000001 0
5 1 1FFFF 00000 1
5 2 008 00000002 0
5 1 00000 1FFFF 1
5 1 20001 00000 1
5 3 1 0FFFD 0
5 2 008 00000002 0
5 1 00000 20001 1
5 3 0 1FFFB 0
5 2 008 00000003 0
5 2 00C 0001FFFC 0
